// File: common/sys_defines.svh
`ifndef SYS_DEFINES_SVH
`define SYS_DEFINES_SVH

// datapath widths
`define DATA_WIDTH          32
`define CSR_ADDR_WIDTH      12
`define REG_IDX_WIDTH       5
`define CSR_FN_WIDTH        2

// machine csr addresses
`define CSR_MSTATUS_ADDR    12'h300
`define CSR_MTVEC_ADDR      12'h305
`define CSR_MEPC_ADDR       12'h341
`define CSR_MCAUSE_ADDR     12'h342
`define CSR_MVENDORID_ADDR  12'hF11
`define CSR_MARCHID_ADDR    12'hF12

// read-only id values
`define MVENDORID_VALUE     32'h0000_0079
`define MARCHID_VALUE       32'h0000_0123

// trap constants
`define MSTATUS_MPP_MASK    32'h0000_1800
`define CAUSE_ECALL_M       32'd11

// low two bits of funct3
`define CSR_FN_WRITE        2'b01
`define CSR_FN_SET          2'b10
`define CSR_FN_CLEAR        2'b11

`define OPC_SYSTEM          7'b1110011

`endif

// File: common/sys_pkg.sv
`include "sys_defines.svh"

package sys_pkg;

	// plain width types
	typedef logic [`DATA_WIDTH-1:0] xlen_t;
	typedef logic [`CSR_ADDR_WIDTH-1:0] csr_addr_t;
	typedef logic [`REG_IDX_WIDTH-1:0] reg_idx_t;
	// write, set or clear, see CSR_FN_* macros
	typedef logic [`CSR_FN_WIDTH-1:0] csr_fn_t;

	// one issued SYSTEM instruction, valid is a single-cycle strobe
	typedef struct packed {
		logic valid;
		xlen_t inst;
		xlen_t pc;
		xlen_t rs1_data;
	} sys_req_t;

	// same-cycle result back to the pipeline
	typedef struct packed {
		logic rd_wr;
		reg_idx_t rd_idx;
		xlen_t rd_data;
		logic redirect;
		xlen_t redirect_pc;
	} sys_resp_t;

	// decode to csr file
	typedef struct packed {
		logic access;
		logic wr_en;
		csr_addr_t addr;
		csr_fn_t fn;
		xlen_t operand;
		logic ecall;
		logic mret;
	} csr_cmd_t;

endpackage

// File: csr/csr_alu.sv
`include "sys_defines.svh"

module csr_alu (
	input sys_pkg::xlen_t old_value,
	input sys_pkg::xlen_t operand,
	input sys_pkg::csr_fn_t fn,
	output sys_pkg::xlen_t new_value
);

	// shared next-value unit for all writable csrs
	always_comb begin
		case (fn)
			`CSR_FN_WRITE: begin
				new_value = operand;
			end
			// set the operand's ones
			`CSR_FN_SET: begin
				new_value = old_value | operand;
			end
			// clear the operand's ones
			`CSR_FN_CLEAR: begin
				new_value = old_value & ~operand;
			end
			default: begin
				new_value = old_value;
			end
		endcase
	end

endmodule

// File: csr/csr_file.sv
`include "sys_defines.svh"

module csr_file (
	input logic clock,
	input logic reset,
	input sys_pkg::csr_cmd_t cmd,
	input sys_pkg::xlen_t pc,
	output sys_pkg::xlen_t rdata,
	input sys_pkg::xlen_t wdata,
	output sys_pkg::xlen_t trap_target
);
	import sys_pkg::*;

	xlen_t mstatus;
	xlen_t mtvec;
	xlen_t mepc;
	xlen_t mcause;
	xlen_t csr_value;
	logic wr_mstatus;
	logic wr_mtvec;
	logic wr_mepc;
	logic wr_mcause;

	// read mux, ids are constants, unknown reads zero
	always_comb begin
		case (cmd.addr)
			`CSR_MSTATUS_ADDR: begin
				csr_value = mstatus;
			end
			`CSR_MTVEC_ADDR: begin
				csr_value = mtvec;
			end
			`CSR_MEPC_ADDR: begin
				csr_value = mepc;
			end
			`CSR_MCAUSE_ADDR: begin
				csr_value = mcause;
			end
			`CSR_MVENDORID_ADDR: begin
				csr_value = `MVENDORID_VALUE;
			end
			`CSR_MARCHID_ADDR: begin
				csr_value = `MARCHID_VALUE;
			end
			default: begin
				csr_value = '0;
			end
		endcase
	end

	// only drive the read port on a csr access
	assign rdata = cmd.access ? csr_value : '0;

	// per-register write strobes
	// ids and unknown addresses have none
	assign wr_mstatus = cmd.wr_en && (cmd.addr == `CSR_MSTATUS_ADDR);
	assign wr_mtvec = cmd.wr_en && (cmd.addr == `CSR_MTVEC_ADDR);
	assign wr_mepc = cmd.wr_en && (cmd.addr == `CSR_MEPC_ADDR);
	assign wr_mcause = cmd.wr_en && (cmd.addr == `CSR_MCAUSE_ADDR);

	// ecall over mret over csr write
	always_ff @(posedge clock) begin
		if (reset) begin
			mstatus <= '0;
		end else if (cmd.ecall) begin
			mstatus <= mstatus | `MSTATUS_MPP_MASK;
		end else if (cmd.mret) begin
			mstatus <= mstatus & ~`MSTATUS_MPP_MASK;
		end else if (wr_mstatus) begin
			mstatus <= wdata;
		end
	end

	// trap vector base, direct mode only
	always_ff @(posedge clock) begin
		if (reset) begin
			mtvec <= '0;
		end else if (wr_mtvec) begin
			mtvec <= wdata;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			mepc <= '0;
		end else if (cmd.ecall) begin
			// pc of the ecall itself
			mepc <= pc;
		end else if (wr_mepc) begin
			mepc <= wdata;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			mcause <= '0;
		end else if (cmd.ecall) begin
			mcause <= `CAUSE_ECALL_M;
		end else if (wr_mcause) begin
			mcause <= wdata;
		end
	end

	// mret returns to mepc, anything else jumps to the aligned vector
	assign trap_target = cmd.mret ? mepc : {mtvec[`DATA_WIDTH-1:2], 2'b00};

	a_trap_exclusive: assert property (
		@(posedge clock) disable iff (reset) !(cmd.ecall && cmd.mret)
	) else $error("csr_file: ecall and mret in the same cycle");

	// a trap or return carries no csr write, the priority chain would drop it
	a_trap_no_write: assert property (
		@(posedge clock) disable iff (reset) (cmd.ecall || cmd.mret) |-> !cmd.wr_en
	) else $error("csr_file: csr write together with ecall or mret");

endmodule

// File: src/sys_decode.sv
`include "sys_defines.svh"

module sys_decode (
	input sys_pkg::sys_req_t req,
	output sys_pkg::csr_cmd_t cmd,
	input sys_pkg::xlen_t csr_rdata,
	input sys_pkg::xlen_t trap_target,
	output sys_pkg::sys_resp_t resp
);
	import sys_pkg::*;

	// funct12 field of the privileged forms
	localparam csr_addr_t FUNCT12_ECALL = 12'h000;
	localparam csr_addr_t FUNCT12_MRET = 12'h302;

	logic [6:0] opcode;
	logic [2:0] funct3;
	reg_idx_t rd;
	reg_idx_t rs1;
	csr_addr_t csr_addr;
	csr_fn_t fn;
	xlen_t zimm_ext;
	logic is_system;
	logic is_csr;
	logic is_priv;
	logic is_ecall;
	logic is_mret;

	// instruction fields
	assign opcode = req.inst[6:0];
	assign rd = req.inst[11:7];
	assign funct3 = req.inst[14:12];
	assign rs1 = req.inst[19:15];
	assign csr_addr = req.inst[31:20];
	assign fn = funct3[1:0];
	// rs1 field doubles as zimm in the immediate forms
	assign zimm_ext = {{(`DATA_WIDTH-`REG_IDX_WIDTH){1'b0}}, rs1};

	assign is_system = req.valid && (opcode == `OPC_SYSTEM);
	// funct3 100 falls out here too
	assign is_csr = is_system && (fn != 2'b00);
	// ecall and mret need rd and rs1 both zero
	assign is_priv = is_system && (funct3 == 3'b000) && (rd == '0) && (rs1 == '0);
	assign is_ecall = is_priv && (csr_addr == FUNCT12_ECALL);
	assign is_mret = is_priv && (csr_addr == FUNCT12_MRET);

	always_comb begin
		cmd.access = is_csr;
		// set and clear with zero source leave the csr alone
		cmd.wr_en = is_csr && ((fn == `CSR_FN_WRITE) || (rs1 != '0));
		cmd.addr = csr_addr;
		cmd.fn = fn;
		cmd.operand = funct3[2] ? zimm_ext : req.rs1_data;
		cmd.ecall = is_ecall;
		cmd.mret = is_mret;
	end

	always_comb begin
		// rd gets the csr value from before this instruction
		resp.rd_wr = is_csr && (rd != '0);
		resp.rd_idx = is_csr ? rd : '0;
		// file returns zero when nothing is accessed
		resp.rd_data = csr_rdata;
		resp.redirect = is_ecall || is_mret;
		resp.redirect_pc = (is_ecall || is_mret) ? trap_target : '0;
	end

endmodule

// File: src/sys_unit.sv
module sys_unit (
	input logic clock,
	input logic reset,
	input sys_pkg::sys_req_t req,
	output sys_pkg::sys_resp_t resp
);
	import sys_pkg::*;

	csr_cmd_t cmd;
	// old value of the addressed csr
	xlen_t csr_rdata;
	// alu result back into the file
	xlen_t csr_wdata;
	xlen_t trap_target;

	sys_decode decode_i (
		.req(req),
		.cmd(cmd),
		.csr_rdata(csr_rdata),
		.trap_target(trap_target),
		.resp(resp)
	);

	csr_alu alu_i (
		.old_value(csr_rdata),
		.operand(cmd.operand),
		.fn(cmd.fn),
		.new_value(csr_wdata)
	);

	// pc feeds mepc on ecall
	csr_file csr_file_i (
		.clock(clock),
		.reset(reset),
		.cmd(cmd),
		.pc(req.pc),
		.rdata(csr_rdata),
		.wdata(csr_wdata),
		.trap_target(trap_target)
	);

endmodule

// File: verif/sys_unit_tb.sv
`include "sys_defines.svh"

module sys_unit_tb;
	import sys_pkg::*;

	logic clock;
	logic reset;
	sys_req_t req;
	sys_resp_t resp;

	// shadow csrs of the reference model
	xlen_t sh_mstatus;
	xlen_t sh_mtvec;
	xlen_t sh_mepc;
	xlen_t sh_mcause;

	sys_resp_t exp_resp;
	int err_count;
	int check_count;
	int test_count;
	int test_err_start;
	xlen_t pc_ctr;
	// random mix scratch
	int kind;
	logic [2:0] rf3;
	reg_idx_t rsrc;
	xlen_t rword;

	sys_unit dut_i (
		.clock(clock),
		.reset(reset),
		.req(req),
		.resp(resp)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// six known csrs, then one unmapped address
	function automatic csr_addr_t addr_of(int i);
		case (i)
			0: return `CSR_MSTATUS_ADDR;
			1: return `CSR_MTVEC_ADDR;
			2: return `CSR_MEPC_ADDR;
			3: return `CSR_MCAUSE_ADDR;
			4: return `CSR_MVENDORID_ADDR;
			5: return `CSR_MARCHID_ADDR;
			default: return 12'h7c0;
		endcase
	endfunction

	function automatic xlen_t csr_inst(logic [2:0] f3, csr_addr_t addr, reg_idx_t src,
		reg_idx_t rd);
		return {addr, src, f3, rd, `OPC_SYSTEM};
	endfunction

	function automatic xlen_t shadow_read(csr_addr_t addr);
		case (addr)
			`CSR_MSTATUS_ADDR: return sh_mstatus;
			`CSR_MTVEC_ADDR: return sh_mtvec;
			`CSR_MEPC_ADDR: return sh_mepc;
			`CSR_MCAUSE_ADDR: return sh_mcause;
			`CSR_MVENDORID_ADDR: return `MVENDORID_VALUE;
			`CSR_MARCHID_ADDR: return `MARCHID_VALUE;
			default: return '0;
		endcase
	endfunction

	// expected same-cycle response against the shadow state
	function automatic sys_resp_t expect_resp(sys_req_t r);
		sys_resp_t e;
		logic [2:0] f3;
		reg_idx_t rd;
		reg_idx_t rs1;
		csr_addr_t addr;
		e = '0;
		f3 = r.inst[14:12];
		rd = r.inst[11:7];
		rs1 = r.inst[19:15];
		addr = r.inst[31:20];
		if (r.valid && (r.inst[6:0] == `OPC_SYSTEM)) begin
			if (f3[1:0] != 2'b00) begin
				e.rd_wr = (rd != '0);
				e.rd_idx = rd;
				e.rd_data = shadow_read(addr);
			end else if ((f3 == 3'b000) && (rd == '0) && (rs1 == '0)) begin
				// ecall goes to the aligned vector
				if (addr == 12'h000) begin
					e.redirect = 1'b1;
					e.redirect_pc = {sh_mtvec[31:2], 2'b00};
				end else if (addr == 12'h302) begin
					e.redirect = 1'b1;
					e.redirect_pc = sh_mepc;
				end
			end
		end
		return e;
	endfunction

	task automatic shadow_update(sys_req_t r);
		logic [2:0] f3;
		reg_idx_t rd;
		reg_idx_t rs1;
		csr_addr_t addr;
		xlen_t opnd;
		xlen_t nv;
		logic we;
		f3 = r.inst[14:12];
		rd = r.inst[11:7];
		rs1 = r.inst[19:15];
		addr = r.inst[31:20];
		opnd = f3[2] ? {27'b0, rs1} : r.rs1_data;
		nv = shadow_read(addr);
		// set and clear need a nonzero source field
		we = (f3[1:0] == 2'b01) || (rs1 != '0);
		if (f3[1:0] == 2'b01) nv = opnd;
		if (f3[1:0] == 2'b10) nv = nv | opnd;
		if (f3[1:0] == 2'b11) nv = nv & ~opnd;
		if (r.valid && (r.inst[6:0] == `OPC_SYSTEM)) begin
			if ((f3[1:0] != 2'b00) && we) begin
				if (addr == `CSR_MSTATUS_ADDR) sh_mstatus = nv;
				if (addr == `CSR_MTVEC_ADDR) sh_mtvec = nv;
				if (addr == `CSR_MEPC_ADDR) sh_mepc = nv;
				if (addr == `CSR_MCAUSE_ADDR) sh_mcause = nv;
			end else if ((f3 == 3'b000) && (rd == '0) && (rs1 == '0)) begin
				if (addr == 12'h000) begin
					sh_mstatus = sh_mstatus | `MSTATUS_MPP_MASK;
					sh_mepc = r.pc;
					sh_mcause = `CAUSE_ECALL_M;
				end else if (addr == 12'h302) begin
					sh_mstatus = sh_mstatus & ~`MSTATUS_MPP_MASK;
				end
			end
		end
	endtask

	// shadow follows the dut at each edge
	always @(posedge clock) begin
		if (reset) begin
			sh_mstatus = '0;
			sh_mtvec = '0;
			sh_mepc = '0;
			sh_mcause = '0;
		end else begin
			shadow_update(req);
		end
	end

	// mid-cycle compare, resp has settled by the falling edge
	always @(negedge clock) begin
		if (!reset) begin
			exp_resp = expect_resp(req);
			check_count++;
			if (resp.rd_wr !== exp_resp.rd_wr) begin
				$display("ERR rd_wr: got %h expected %h", resp.rd_wr, exp_resp.rd_wr);
				err_count++;
			end
			if (resp.rd_idx !== exp_resp.rd_idx) begin
				$display("ERR rd_idx: got %h expected %h", resp.rd_idx, exp_resp.rd_idx);
				err_count++;
			end
			if (resp.rd_data !== exp_resp.rd_data) begin
				$display("ERR rd_data: got %h expected %h", resp.rd_data, exp_resp.rd_data);
				err_count++;
			end
			if (resp.redirect !== exp_resp.redirect) begin
				$display("ERR redirect: got %h expected %h", resp.redirect, exp_resp.redirect);
				err_count++;
			end
			if (resp.redirect_pc !== exp_resp.redirect_pc) begin
				$display("ERR redirect_pc: got %h expected %h", resp.redirect_pc,
					exp_resp.redirect_pc);
				err_count++;
			end
		end
	end

	// one cycle per instruction, entered 5 units after an edge
	task automatic issue(xlen_t inst, xlen_t rs1_data);
		req.valid = 1'b1;
		req.inst = inst;
		req.pc = pc_ctr;
		req.rs1_data = rs1_data;
		pc_ctr = pc_ctr + 32'd4;
		@(posedge clock);
		#5;
		req.valid = 1'b0;
	endtask

	task automatic end_test(string name);
		test_count++;
		$display("test %0d %s: %0d errors", test_count, name, err_count - test_err_start);
		test_err_start = err_count;
	endtask

	// watchdog on the whole run
	initial begin
		int cycles;
		cycles = 0;
		while (cycles < 5000) begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout: run did not finish within 5000 cycles");
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		void'($urandom(32'hc8d4_a8a6));
		reset = 1'b1;
		req = '0;
		err_count = 0;
		check_count = 0;
		test_count = 0;
		test_err_start = 0;
		pc_ctr = 32'h0000_1000;
		repeat (8) @(posedge clock);
		#5;
		reset = 1'b0;

		// reads with rs1 x0 write nothing
		for (int i = 0; i < 6; i++) issue(csr_inst(3'b010, addr_of(i), 5'd0, 5'd1), '1);
		issue(csr_inst(3'b001, `CSR_MVENDORID_ADDR, 5'd2, 5'd3), 32'hdead_beef);
		issue(csr_inst(3'b101, `CSR_MARCHID_ADDR, 5'h1f, 5'd3), '0);
		issue(csr_inst(3'b010, `CSR_MVENDORID_ADDR, 5'd0, 5'd4), '0);
		issue(csr_inst(3'b010, `CSR_MARCHID_ADDR, 5'd0, 5'd4), '0);
		end_test("reset values and ids");

		issue(csr_inst(3'b001, `CSR_MTVEC_ADDR, 5'd2, 5'd5), 32'h1234_5678);
		issue(csr_inst(3'b010, `CSR_MTVEC_ADDR, 5'd2, 5'd5), 32'h0000_00ff);
		issue(csr_inst(3'b011, `CSR_MTVEC_ADDR, 5'd2, 5'd5), 32'h0000_0f0f);
		issue(csr_inst(3'b101, `CSR_MEPC_ADDR, 5'h15, 5'd6), '0);
		issue(csr_inst(3'b110, `CSR_MEPC_ADDR, 5'h0a, 5'd6), '0);
		issue(csr_inst(3'b111, `CSR_MEPC_ADDR, 5'h03, 5'd6), '0);
		issue(csr_inst(3'b010, `CSR_MTVEC_ADDR, 5'd0, 5'd7), '0);
		issue(csr_inst(3'b010, `CSR_MEPC_ADDR, 5'd0, 5'd7), '0);
		end_test("write set clear forms");

		// zero source field, rs1 data ignored
		issue(csr_inst(3'b010, `CSR_MTVEC_ADDR, 5'd0, 5'd7), '1);
		issue(csr_inst(3'b011, `CSR_MTVEC_ADDR, 5'd0, 5'd7), '1);
		issue(csr_inst(3'b110, `CSR_MEPC_ADDR, 5'd0, 5'd7), '0);
		issue(csr_inst(3'b111, `CSR_MEPC_ADDR, 5'd0, 5'd7), '0);
		// rd x0 still writes
		issue(csr_inst(3'b001, `CSR_MCAUSE_ADDR, 5'd9, 5'd0), 32'h0000_00aa);
		issue(csr_inst(3'b101, `CSR_MSTATUS_ADDR, 5'h08, 5'd0), '0);
		for (int i = 0; i < 4; i++) issue(csr_inst(3'b010, addr_of(i), 5'd0, 5'd8), '0);
		end_test("zero source and rd x0");

		issue(csr_inst(3'b001, `CSR_MTVEC_ADDR, 5'd3, 5'd0), 32'h8000_0103);
		pc_ctr = 32'h0000_2468;
		issue({12'h000, 13'd0, `OPC_SYSTEM}, '0);
		for (int i = 0; i < 4; i++) issue(csr_inst(3'b010, addr_of(i), 5'd0, 5'd9), '0);
		end_test("ecall");

		issue(csr_inst(3'b001, `CSR_MEPC_ADDR, 5'd3, 5'd1), 32'h0000_4000);
		issue({12'h302, 13'd0, `OPC_SYSTEM}, '0);
		issue(csr_inst(3'b010, `CSR_MSTATUS_ADDR, 5'd0, 5'd1), '0);
		issue(csr_inst(3'b001, 12'h7c0, 5'd3, 5'd1), 32'h5555_aaaa);
		issue(csr_inst(3'b010, 12'h7c0, 5'd3, 5'd1), 32'hffff_0000);
		issue(csr_inst(3'b010, 12'h7c0, 5'd0, 5'd1), '0);
		end_test("mret and unknown csr");

		for (int n = 0; n < 300; n++) begin
			kind = $urandom_range(0, 9);
			rword = $urandom();
			rsrc = ($urandom_range(0, 3) == 0) ? 5'd0 : 5'($urandom());
			rf3 = 3'($urandom());
			if (kind == 0) begin
				// valid low with a live csr encoding on the bus
				req.valid = 1'b0;
				req.inst = csr_inst(rf3 | 3'b001, addr_of($urandom_range(0, 6)), rsrc,
					5'($urandom()));
				req.rs1_data = $urandom();
				@(posedge clock);
				#5;
			end else if (kind == 1) begin
				// any opcode but SYSTEM
				if (rword[6:0] == `OPC_SYSTEM) rword[4] = 1'b0;
				issue(rword, $urandom());
			end else if (kind == 2) begin
				pc_ctr = {rword[31:2], 2'b00};
				issue({12'h000, 13'd0, `OPC_SYSTEM}, '0);
			end else if (kind == 3) begin
				issue({12'h302, 13'd0, `OPC_SYSTEM}, '0);
			end else begin
				issue(csr_inst(rf3, addr_of($urandom_range(0, 6)), rsrc, 5'($urandom())),
					$urandom());
			end
		end
		end_test("random mix");

		req = '0;
		@(posedge clock);
		#5;
		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
		if (err_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: tb.f
+incdir+common
common/sys_pkg.sv
csr/csr_alu.sv
csr/csr_file.sv
src/sys_decode.sv
src/sys_unit.sv
verif/sys_unit_tb.sv

// File: Bender.yml
package:
  name: sys_unit

sources:
  - include_dirs:
      - common
    files:
      - common/sys_pkg.sv
      - csr/csr_alu.sv
      - csr/csr_file.sv
      - src/sys_decode.sv
      - src/sys_unit.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/sys_unit_tb.sv
